//--- soc_bus.f
soc_bus_pkg.sv
soc_bus_addr_decode.sv
soc_bus_rr_arbiter.sv
soc_bus_target_ctrl.sv
soc_bus_route.sv
soc_bus.sv
soc_bus_props.sv
soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - files:
      - soc_bus_pkg.sv
      - soc_bus_addr_decode.sv
      - soc_bus_rr_arbiter.sv
      - soc_bus_target_ctrl.sv
      - soc_bus_route.sv
      - soc_bus.sv
  - target: test
    files:
      - soc_bus_props.sv
      - soc_bus_tb.sv

//--- soc_bus_tb.sv
/* Testbench of the SoC interconnect
   Random initiators and target models, checked by assertions */
`timescale 1ns/10ps

module soc_bus_tb
  import soc_bus_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic clk_i = 1'b0;
  logic rst_n = 1'b0;
  logic [N_INIT-1:0] init_req_valid = '0;
  addr_t [N_INIT-1:0] init_req_addr = '0;
  logic [N_INIT-1:0] init_req_write = '0;
  data_t [N_INIT-1:0] init_req_wdata = '0;
  logic [N_INIT-1:0] init_req_ready;
  logic [N_INIT-1:0] init_rsp_valid;
  data_t [N_INIT-1:0] init_rsp_rdata;
  logic [N_INIT-1:0] init_rsp_err;
  logic [N_INIT-1:0] init_rsp_ready = '0;
  logic [N_TGT-1:0] tgt_req_valid;
  addr_t [N_TGT-1:0] tgt_req_addr;
  logic [N_TGT-1:0] tgt_req_write;
  data_t [N_TGT-1:0] tgt_req_wdata;
  logic [N_TGT-1:0] tgt_req_ready = '0;
  logic [N_TGT-1:0] tgt_rsp_valid = '0;
  data_t [N_TGT-1:0] tgt_rsp_rdata = '0;
  logic [N_TGT-1:0] tgt_rsp_ready;

  integer seed = 32'h711d7a48;
  int errors = 0;
  int timeouts = 0;
  bit overlap_seen = 1'b0;
  int tgt_hs_cnt [N_TGT] = '{default: 0};

  soc_bus dut (.*);

  always #5 clk_i = ~clk_i;

  // Address window of each target, built from the address map
  function automatic bit in_window(input int t, input addr_t a);
    addr_t lo;
    lo = CL_BASE + addr_t'(t) * CL_STRIDE;
    if (t < N_CLUSTERS) begin
      return a >= lo && a - lo < CL_SIZE;
    end
    if (t == int'(IDX_L2)) begin
      return a >= L2_BASE && a - L2_BASE < L2_SIZE;
    end
    return a <= LOW_END || (a >= PERIPH_BASE && a <= PERIPH_END) || a >= L2_BASE + L2_SIZE;
  endfunction

  // Kinds 0 to 5 are windows, anything else is a gap
  function automatic addr_t rand_addr(input int kind, input addr_t off);
    addr_t a;
    case (kind)
      0: a = off & LOW_END;
      1, 2: a = CL_BASE + addr_t'(kind - 1) * CL_STRIDE + off % CL_SIZE;
      3: a = PERIPH_BASE + off % (PERIPH_END - PERIPH_BASE + 1);
      4: a = L2_BASE + off % L2_SIZE;
      5: a = L2_BASE + L2_SIZE + off % (addr_t'(0) - L2_BASE - L2_SIZE);
      default: a = off[31] ? CL_BASE + CL_SIZE + off % (CL_STRIDE - CL_SIZE) :
                             PERIPH_END + 1 + off % (L2_BASE - PERIPH_END - 1);
    endcase
    return a & ~addr_t'(3);
  endfunction

  function automatic int kind_target(input int kind);
    case (kind)
      1, 2: return kind - 1;
      4: return int'(IDX_L2);
      0, 3, 5: return int'(IDX_EXT);
      default: return -1;
    endcase
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Handshakes counted at the negedge before the edge that takes them
  always @(negedge clk_i) begin
    for (int t = 0; t < N_TGT; t++) begin
      if (tgt_req_valid[t] && tgt_req_ready[t]) begin
        tgt_hs_cnt[t]++;
      end
    end
    if ($countones(tgt_req_valid | tgt_rsp_valid) >= 2) begin
      overlap_seen = 1'b1;
    end
  end

  for (genvar t = 0; t < N_TGT; t++) begin : gen_window_chk
    assert property (@(posedge clk_i) disable iff (!rst_n)
      tgt_req_valid[t] |-> in_window(t, tgt_req_addr[t]))
      else begin
        errors++;
        $display("mismatch window_t%0d expected addr in window actual %h", t,
                 $sampled(tgt_req_addr[t]));
      end
  end

  task automatic serve_target(input int t);
    int cnt;
    bit hs;
    data_t rdata;
    forever begin
      @(negedge clk_i);
      if (tgt_req_valid[t]) begin
        rdata = tgt_req_addr[t] ^ (data_t'(t) * 32'h1111_1111);
        repeat ($unsigned($random(seed)) % 4 + 1) step();
        tgt_req_ready[t] = 1'b1;
        step();
        tgt_req_ready[t] = 1'b0;
        repeat ($unsigned($random(seed)) % 5) step();
        tgt_rsp_rdata[t] = rdata;
        tgt_rsp_valid[t] = 1'b1;
        cnt = 0;
        hs = 1'b0;
        while (!hs && cnt < TIMEOUT) begin
          @(negedge clk_i);
          hs = tgt_rsp_ready[t];
          step();
          cnt++;
        end
        tgt_rsp_valid[t] = 1'b0;
        if (!hs) begin
          timeouts++;
          $display("timeout: target %0d response was never taken", t);
        end
      end
    end
  endtask

  // Negative kind_sel picks a random window or gap per request
  task automatic drive_initiator(input int i, input int n_ops, input int kind_sel);
    int kind;
    int tgt;
    int cnt;
    int hs_start;
    bit hs;
    data_t rdata;
    logic err;
    string name;
    logic [ADDR_W+DATA_W+1:0] req_seen;
    logic [ADDR_W+DATA_W+1:0] req_want;
    for (int n = 0; n < n_ops; n++) begin
      kind = kind_sel >= 0 ? kind_sel : $unsigned($random(seed)) % 7;
      tgt = kind_target(kind);
      name = $sformatf("init%0d_op%0d", i, n);
      init_req_addr[i] = rand_addr(kind, $random(seed));
      init_req_write[i] = 1'($random(seed));
      init_req_wdata[i] = $random(seed);
      init_req_valid[i] = 1'b1;
      hs_start = tgt >= 0 ? tgt_hs_cnt[tgt] : 0;
      req_seen = '0;
      cnt = 0;
      hs = 1'b0;
      while (!hs && cnt < TIMEOUT) begin
        @(negedge clk_i);
        hs = init_req_ready[i];
        // Target side view of the beat being accepted
        if (hs && tgt >= 0) begin
          req_seen = {tgt_req_valid[tgt] && tgt_req_ready[tgt], tgt_req_write[tgt],
                      tgt_req_addr[tgt], tgt_req_wdata[tgt]};
        end
        step();
        cnt++;
      end
      init_req_valid[i] = 1'b0;
      if (!hs) begin
        timeouts++;
        $display("timeout: initiator %0d request was never accepted", i);
        return;
      end
      if (tgt >= 0) begin
        req_want = {1'b1, init_req_write[i], init_req_addr[i], init_req_wdata[i]};
        assert (req_seen == req_want)
          else begin
            errors++;
            $display("mismatch %s_fields expected %h actual %h", name, req_want, req_seen);
          end
        assert (tgt_hs_cnt[tgt] - hs_start <= N_INIT)
          else begin
            errors++;
            $display("mismatch %s_grants expected %0d actual %0d", name, N_INIT,
                     tgt_hs_cnt[tgt] - hs_start);
          end
      end
      cnt = 0;
      hs = 1'b0;
      while (!hs && cnt < TIMEOUT) begin
        init_rsp_ready[i] = 1'($random(seed));
        @(negedge clk_i);
        hs = init_rsp_valid[i] && init_rsp_ready[i];
        rdata = init_rsp_rdata[i];
        err = init_rsp_err[i];
        step();
        cnt++;
      end
      init_rsp_ready[i] = 1'b0;
      if (!hs) begin
        timeouts++;
        $display("timeout: initiator %0d got no response", i);
        return;
      end
      if (tgt < 0) begin
        assert (err && rdata == '0)
          else begin
            errors++;
            $display("mismatch %s_gap expected err 1 rdata 0 actual err %0b rdata %h",
                     name, err, rdata);
          end
      end else begin
        assert (!err)
          else begin
            errors++;
            $display("mismatch %s_err expected 0 actual %0b", name, err);
          end
        assert (init_req_write[i] ||
                rdata == (init_req_addr[i] ^ (data_t'(tgt) * 32'h1111_1111)))
          else begin
            errors++;
            $display("mismatch %s_rdata expected %h actual %h", name,
                     init_req_addr[i] ^ (data_t'(tgt) * 32'h1111_1111), rdata);
          end
      end
    end
  endtask

  task automatic report_result();
    int prop_fails;
    prop_fails = dut.props.fail_cnt;
    $display("errors %0d timeouts %0d bound assertion failures %0d",
             errors, timeouts, prop_fails);
    if (errors == 0 && timeouts == 0 && prop_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    repeat (5) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    fork
      serve_target(0);
      serve_target(1);
      serve_target(2);
      serve_target(3);
    join_none
    // Mixed traffic over every window and the gaps
    fork
      drive_initiator(0, 60, -1);
      drive_initiator(1, 60, -1);
      drive_initiator(2, 60, -1);
    join
    // Every initiator hammers the L2 port
    fork
      drive_initiator(0, 20, 4);
      drive_initiator(1, 20, 4);
      drive_initiator(2, 20, 4);
    join
    assert (overlap_seen)
      else begin
        errors++;
        $display("no two targets were ever busy at the same time");
      end
    report_result();
  end

endmodule

//--- soc_bus_props.sv
/* Protocol checks bound into the SoC interconnect
   Back-pressure stability, reset state and one transaction per initiator */
`timescale 1ns/10ps

module soc_bus_props
  import soc_bus_pkg::*;
(
  input logic               clk_i,
  input logic               rst_n,
  input logic  [N_INIT-1:0] init_req_valid,
  input logic  [N_INIT-1:0] init_req_ready,
  input logic  [N_INIT-1:0] init_rsp_valid,
  input data_t [N_INIT-1:0] init_rsp_rdata,
  input logic  [N_INIT-1:0] init_rsp_err,
  input logic  [N_INIT-1:0] init_rsp_ready,
  input logic  [N_TGT-1:0]  tgt_req_valid,
  input addr_t [N_TGT-1:0]  tgt_req_addr,
  input logic  [N_TGT-1:0]  tgt_req_write,
  input data_t [N_TGT-1:0]  tgt_req_wdata,
  input logic  [N_TGT-1:0]  tgt_req_ready,
  input logic  [N_TGT-1:0]  tgt_rsp_valid,
  input logic  [N_TGT-1:0]  tgt_rsp_ready
);

  int unsigned fail_cnt = 0;
  logic [N_INIT-1:0] pending;

  // Set on request accept, cleared on response accept
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending | (init_req_valid & init_req_ready)) &
                 ~(init_rsp_valid & init_rsp_ready);
    end
  end

  assert property (@(posedge clk_i) !rst_n |=> tgt_req_valid == '0 &&
    init_rsp_valid == '0 && init_req_ready == '0 && tgt_rsp_ready == '0)
    else begin
      fail_cnt++;
      $error("handshake output high in the first cycle after reset");
    end

  for (genvar t = 0; t < N_TGT; t++) begin : gen_tgt
    assert property (@(posedge clk_i) disable iff (!rst_n)
      tgt_req_valid[t] && !tgt_req_ready[t] |=> tgt_req_valid[t] &&
        $stable(tgt_req_addr[t]) && $stable(tgt_req_write[t]) && $stable(tgt_req_wdata[t]))
      else begin
        fail_cnt++;
        $error("target %0d request changed under back-pressure", t);
      end
  end

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    assert property (@(posedge clk_i) disable iff (!rst_n)
      init_rsp_valid[i] && !init_rsp_ready[i] |=> init_rsp_valid[i] &&
        $stable(init_rsp_rdata[i]) && $stable(init_rsp_err[i]))
      else begin
        fail_cnt++;
        $error("initiator %0d response changed under back-pressure", i);
      end
    assert property (@(posedge clk_i) disable iff (!rst_n) init_req_valid[i] |-> !pending[i])
      else begin
        fail_cnt++;
        $error("initiator %0d issued a second outstanding request", i);
      end
  end

  // Two targets busy together
  cover property (@(posedge clk_i) disable iff (!rst_n)
    $countones(tgt_req_valid | tgt_rsp_valid) >= 2);

endmodule

bind soc_bus soc_bus_props props (.*);

//--- soc_bus.sv
/* SoC interconnect top level
   Decodes, arbitrates and routes single-beat requests to four targets */
`timescale 1ns/10ps

module soc_bus
  import soc_bus_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n,
  // Initiator side
  input  logic        [N_INIT-1:0] init_req_valid,
  input  addr_t       [N_INIT-1:0] init_req_addr,
  input  logic        [N_INIT-1:0] init_req_write,
  input  data_t       [N_INIT-1:0] init_req_wdata,
  output logic        [N_INIT-1:0] init_req_ready,
  output logic        [N_INIT-1:0] init_rsp_valid,
  output data_t       [N_INIT-1:0] init_rsp_rdata,
  output logic        [N_INIT-1:0] init_rsp_err,
  input  logic        [N_INIT-1:0] init_rsp_ready,
  // Target side
  output logic        [N_TGT-1:0]  tgt_req_valid,
  output addr_t       [N_TGT-1:0]  tgt_req_addr,
  output logic        [N_TGT-1:0]  tgt_req_write,
  output data_t       [N_TGT-1:0]  tgt_req_wdata,
  input  logic        [N_TGT-1:0]  tgt_req_ready,
  input  logic        [N_TGT-1:0]  tgt_rsp_valid,
  input  data_t       [N_TGT-1:0]  tgt_rsp_rdata,
  output logic        [N_TGT-1:0]  tgt_rsp_ready
);

  slot_idx_t   [N_INIT-1:0] dec_slot;
  init_mask_t  [N_SLOT-1:0] slot_req;
  init_idx_t   [N_SLOT-1:0] arb_grant;
  logic        [N_SLOT-1:0] arb_grant_valid;
  logic        [N_SLOT-1:0] arb_advance;
  init_idx_t   [N_SLOT-1:0] owner;
  slot_state_e [N_SLOT-1:0] slot_state;
  logic        [N_INIT-1:0] init_busy;

  for (genvar i = 0; i < N_INIT; i++) begin : gen_decode
    soc_bus_addr_decode i_decode (
      .addr (init_req_addr[i]),
      .slot (dec_slot[i])
    );
  end

  // Owners of an active slot must not request again
  always_comb begin
    init_busy = '0;
    for (int s = 0; s < N_SLOT; s++) begin
      if (slot_state[s] != SLOT_IDLE) begin
        init_busy[owner[s]] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < N_SLOT; s++) begin
      for (int i = 0; i < N_INIT; i++) begin
        slot_req[s][i] = init_req_valid[i] && !init_busy[i] &&
                         dec_slot[i] == slot_idx_t'(s);
      end
    end
  end

  for (genvar s = 0; s < N_SLOT; s++) begin : gen_arb
    soc_bus_rr_arbiter i_arb (
      .clk_i       (clk_i),
      .rst_n       (rst_n),
      .req         (slot_req[s]),
      .advance     (arb_advance[s]),
      .grant       (arb_grant[s]),
      .grant_valid (arb_grant_valid[s])
    );
  end

  soc_bus_target_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .slot_req        (slot_req),
    .arb_grant       (arb_grant),
    .arb_grant_valid (arb_grant_valid),
    .tgt_req_ready   (tgt_req_ready),
    .tgt_rsp_valid   (tgt_rsp_valid),
    .init_rsp_ready  (init_rsp_ready),
    .arb_advance     (arb_advance),
    .owner           (owner),
    .slot_state      (slot_state),
    .tgt_req_valid   (tgt_req_valid),
    .tgt_rsp_ready   (tgt_rsp_ready),
    .init_req_ready  (init_req_ready),
    .init_rsp_valid  (init_rsp_valid),
    .init_rsp_err    (init_rsp_err)
  );

  soc_bus_route i_route (
    .owner          (owner),
    .slot_state     (slot_state),
    .init_req_addr  (init_req_addr),
    .init_req_write (init_req_write),
    .init_req_wdata (init_req_wdata),
    .tgt_rsp_rdata  (tgt_rsp_rdata),
    .tgt_req_addr   (tgt_req_addr),
    .tgt_req_write  (tgt_req_write),
    .tgt_req_wdata  (tgt_req_wdata),
    .init_rsp_rdata (init_rsp_rdata)
  );

endmodule

//--- soc_bus_route.sv
/* Datapath of the SoC interconnect
   Steers request fields to the targets and read data back to the owners */
`timescale 1ns/10ps

module soc_bus_route
  import soc_bus_pkg::*;
(
  input  init_idx_t   [N_SLOT-1:0] owner,
  input  slot_state_e [N_SLOT-1:0] slot_state,
  input  addr_t       [N_INIT-1:0] init_req_addr,
  input  logic        [N_INIT-1:0] init_req_write,
  input  data_t       [N_INIT-1:0] init_req_wdata,
  input  data_t       [N_TGT-1:0]  tgt_rsp_rdata,
  output addr_t       [N_TGT-1:0]  tgt_req_addr,
  output logic        [N_TGT-1:0]  tgt_req_write,
  output data_t       [N_TGT-1:0]  tgt_req_wdata,
  output data_t       [N_INIT-1:0] init_rsp_rdata
);

  // Read data per slot, error slot always returns zero
  data_t [N_SLOT-1:0] slot_rdata;

  assign slot_rdata = {data_t'(0), tgt_rsp_rdata};

  // Each target sees the fields of its current owner
  always_comb begin
    for (int t = 0; t < N_TGT; t++) begin
      tgt_req_addr[t]  = init_req_addr[owner[t]];
      tgt_req_write[t] = init_req_write[owner[t]];
      tgt_req_wdata[t] = init_req_wdata[owner[t]];
    end
  end

  // An initiator owns at most one slot in response phase
  always_comb begin
    init_rsp_rdata = '0;
    for (int i = 0; i < N_INIT; i++) begin
      for (int s = 0; s < N_SLOT; s++) begin
        if (slot_state[s] == SLOT_RSP && owner[s] == init_idx_t'(i)) begin
          init_rsp_rdata[i] = slot_rdata[s];
        end
      end
    end
  end

endmodule

//--- soc_bus_target_ctrl.sv
/* Slot control of the SoC interconnect
   Per slot ownership FSM with handshake steering and the error response */
`timescale 1ns/10ps

module soc_bus_target_ctrl
  import soc_bus_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n,
  input  init_mask_t  [N_SLOT-1:0]    slot_req,
  input  init_idx_t   [N_SLOT-1:0]    arb_grant,
  input  logic        [N_SLOT-1:0]    arb_grant_valid,
  input  logic        [N_TGT-1:0]     tgt_req_ready,
  input  logic        [N_TGT-1:0]     tgt_rsp_valid,
  input  logic        [N_INIT-1:0]    init_rsp_ready,
  output logic        [N_SLOT-1:0]    arb_advance,
  output init_idx_t   [N_SLOT-1:0]    owner,
  output slot_state_e [N_SLOT-1:0]    slot_state,
  output logic        [N_TGT-1:0]     tgt_req_valid,
  output logic        [N_TGT-1:0]     tgt_rsp_ready,
  output logic        [N_INIT-1:0]    init_req_ready,
  output logic        [N_INIT-1:0]    init_rsp_valid,
  output logic        [N_INIT-1:0]    init_rsp_err
);

  slot_state_e [N_SLOT-1:0] state_d;
  init_idx_t   [N_SLOT-1:0] owner_d;
  logic        [N_SLOT-1:0] slot_req_ready;
  logic        [N_SLOT-1:0] slot_rsp_valid;
  logic        [N_SLOT-1:0] slot_rsp_ready;

  // Target side handshakes per slot
  always_comb begin
    for (int s = 0; s < N_TGT; s++) begin
      slot_req_ready[s] = tgt_req_ready[s];
      slot_rsp_valid[s] = tgt_rsp_valid[s];
    end
    // Error slot accepts and answers without delay
    slot_req_ready[IDX_ERR] = 1'b1;
    slot_rsp_valid[IDX_ERR] = 1'b1;
    for (int s = 0; s < N_SLOT; s++) begin
      slot_rsp_ready[s] = init_rsp_ready[owner[s]];
    end
  end

  always_comb begin
    state_d     = slot_state;
    owner_d     = owner;
    arb_advance = '0;
    for (int s = 0; s < N_SLOT; s++) begin
      case (slot_state[s])
        SLOT_IDLE: begin
          // Take the grant only while its request is still raised
          if (arb_grant_valid[s] && slot_req[s][arb_grant[s]]) begin
            arb_advance[s] = 1'b1;
            owner_d[s]     = arb_grant[s];
            state_d[s]     = SLOT_REQ;
          end
        end
        SLOT_REQ: begin
          if (slot_req_ready[s]) begin
            state_d[s] = SLOT_RSP;
          end
        end
        SLOT_RSP: begin
          if (slot_rsp_valid[s] && slot_rsp_ready[s]) begin
            state_d[s] = SLOT_IDLE;
          end
        end
        default: begin
          state_d[s] = SLOT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      for (int s = 0; s < N_SLOT; s++) begin
        slot_state[s] <= SLOT_IDLE;
        owner[s]      <= '0;
      end
    end else begin
      slot_state <= state_d;
      owner      <= owner_d;
    end
  end

  // Strobes toward the targets
  always_comb begin
    for (int t = 0; t < N_TGT; t++) begin
      tgt_req_valid[t] = slot_state[t] == SLOT_REQ;
      tgt_rsp_ready[t] = slot_state[t] == SLOT_RSP && slot_rsp_ready[t];
    end
  end

  // Strobes back to the owning initiators
  always_comb begin
    init_req_ready = '0;
    init_rsp_valid = '0;
    for (int i = 0; i < N_INIT; i++) begin
      for (int s = 0; s < N_SLOT; s++) begin
        if (owner[s] == init_idx_t'(i)) begin
          if (slot_state[s] == SLOT_REQ && slot_req_ready[s]) begin
            init_req_ready[i] = 1'b1;
          end
          if (slot_state[s] == SLOT_RSP && slot_rsp_valid[s]) begin
            init_rsp_valid[i] = 1'b1;
          end
        end
      end
      init_rsp_err[i] = slot_state[IDX_ERR] == SLOT_RSP && owner[IDX_ERR] == init_idx_t'(i);
    end
  end

endmodule

//--- soc_bus_rr_arbiter.sv
/* Round-robin arbiter for one slot
   Picks the first requesting initiator at or after the priority pointer */
`timescale 1ns/10ps

module soc_bus_rr_arbiter
  import soc_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n,
  input  init_mask_t req,
  input  logic       advance,
  output init_idx_t  grant,
  output logic       grant_valid
);

  init_idx_t prio_q;

  // Scan downward so the requester nearest to the pointer wins
  always_comb begin
    int unsigned idx;

    grant       = '0;
    grant_valid = 1'b0;
    for (int k = N_INIT - 1; k >= 0; k--) begin
      idx = (int'(prio_q) + k) % N_INIT;
      if (req[idx]) begin
        grant       = init_idx_t'(idx);
        grant_valid = 1'b1;
      end
    end
  end

  // Pointer moves past the winner once the grant is taken
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      prio_q <= '0;
    end else if (advance) begin
      if (grant == init_idx_t'(N_INIT - 1)) begin
        prio_q <= '0;
      end else begin
        prio_q <= grant + init_idx_t'(1);
      end
    end
  end

endmodule

//--- soc_bus_addr_decode.sv
/* Address decoder of the SoC interconnect
   Maps one initiator address to a target slot or the error slot */
`timescale 1ns/10ps

module soc_bus_addr_decode
  import soc_bus_pkg::*;
(
  input  addr_t     addr,
  output slot_idx_t slot
);

  always_comb begin
    addr_t win_lo;

    win_lo = CL_BASE;
    // Gaps fall through to the error slot
    slot   = IDX_ERR;

    // Low memory below the clusters
    if (addr <= LOW_END) begin
      slot = IDX_EXT;
    end

    // Cluster windows
    for (int i = 0; i < N_CLUSTERS; i++) begin
      win_lo = CL_BASE + addr_t'(i) * CL_STRIDE;
      if (addr >= win_lo && addr < win_lo + CL_SIZE) begin
        slot = slot_idx_t'(i);
      end
    end

    // Peripheral block at 0x1A..
    if (addr >= PERIPH_BASE && addr <= PERIPH_END) begin
      slot = IDX_EXT;
    end

    if (addr >= L2_BASE && addr < L2_BASE + L2_SIZE) begin
      slot = IDX_L2;
    end

    // Whole space above L2 is external
    if (addr >= L2_BASE + L2_SIZE) begin
      slot = IDX_EXT;
    end
  end

endmodule

//--- soc_bus_pkg.sv
/* SoC interconnect shared definitions
   Widths, port counts, address map and slot states */
package soc_bus_pkg;

  // Data path widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Initiators are the clusters plus the external slave port
  localparam int unsigned N_CLUSTERS = 2;
  localparam int unsigned N_INIT     = N_CLUSTERS + 1;

  // Targets are the clusters, the L2 port and the external master port
  localparam int unsigned N_TGT  = N_CLUSTERS + 2;
  // One more slot catches decode errors inside the bus
  localparam int unsigned N_SLOT = N_TGT + 1;

  typedef logic [$clog2(N_INIT)-1:0] init_idx_t;
  typedef logic [$clog2(N_SLOT)-1:0] slot_idx_t;
  typedef logic [N_INIT-1:0]         init_mask_t;

  // Slot indices of the fixed targets
  localparam slot_idx_t IDX_L2  = slot_idx_t'(N_CLUSTERS);
  localparam slot_idx_t IDX_EXT = IDX_L2 + slot_idx_t'(1);
  localparam slot_idx_t IDX_ERR = slot_idx_t'(N_TGT);

  // Cluster windows, one per cluster at a fixed stride
  localparam addr_t CL_BASE   = 32'h1000_0000;
  localparam addr_t CL_STRIDE = 32'h0040_0000;
  localparam addr_t CL_SIZE   = 32'h0030_0000;

  // External windows below the clusters and for the peripherals
  localparam addr_t LOW_END     = 32'h0FFF_FFFF;
  localparam addr_t PERIPH_BASE = 32'h1A00_0000;
  localparam addr_t PERIPH_END  = 32'h1AFF_FFFF;

  // L2 memory, everything above it goes external again
  localparam addr_t L2_BASE = 32'h1C00_0000;
  localparam addr_t L2_SIZE = 32'h0010_0000;

  // Per slot transaction phase
  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_REQ,
    SLOT_RSP
  } slot_state_e;

endpackage
